//--- Bender.yml
package:
  name: cache_sim

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/cache_ctrl.sv
      - hw/wt_buffer.sv
      - hw/backend_ram.sv
      - hw/cache_sim_wrapper.sv
  - target: test
    files:
      - bench/cache_props.sv
      - bench/cache_tb.sv

//--- bench/cache_props.sv
`timescale 1ns/1ps

module cache_props (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    iob_valid_i,
  input logic                    iob_write_i,
  input logic                    iob_ready_o,
  input logic                    iob_rvalid_o,
  input logic                    be_valid_o,
  input logic                    push_o,
  input logic                    full_i,
  input logic                    empty_i,
  input cache_pkg::cache_state_t state_i
);
  import cache_pkg::*;

  int   fails = 0;
  logic rd_pending_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) rd_pending_q <= 1'b0;
    else if (iob_rvalid_o) rd_pending_q <= 1'b0; // answered
    else if (iob_valid_i && iob_ready_o && !iob_write_i) rd_pending_q <= 1'b1;
  end

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
    iob_rvalid_o |-> rd_pending_q)
    else begin
      $error("iob_rvalid_o high without an accepted read");
      fails++;
    end

  ready_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_pending_q |-> !iob_ready_o)
    else begin
      $error("iob_ready_o high while a read is outstanding");
      fails++;
    end

  refill_after_drain: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_i == REFILL_REQ && be_valid_o) |-> empty_i)
    else begin
      $error("refill read issued while the write buffer holds entries");
      fails++;
    end

  push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    push_o |-> !full_i)
    else begin
      $error("push into a full write buffer");
      fails++;
    end

endmodule

bind cache_ctrl cache_props u_props (
  .clk_i(clk_i), .reset_i(reset_i), .iob_valid_i(iob_valid_i),
  .iob_write_i(|iob_wstrb_i), .iob_ready_o(iob_ready_o), .iob_rvalid_o(iob_rvalid_o),
  .be_valid_o(be_valid_o), .push_o(push_o), .full_i(full_i), .empty_i(empty_i),
  .state_i(state_q)
);

//--- bench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  localparam int ADDR_W       = DEF_ADDR_W;
  localparam int DATA_W       = DEF_DATA_W;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int OP_CYCLES    = 16; // miss behind a draining buffer, with slack
  localparam int TOTAL_OPS    = 4 + 8 + 20 + 24 + 21;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + TOTAL_OPS * OP_CYCLES) * CLK_PERIOD * 4;

  logic                clk_i, reset_i;
  logic                iob_valid_i, iob_rvalid_o, iob_ready_o;
  logic [ADDR_W-1:0]   iob_addr_i;
  logic [DATA_W-1:0]   iob_wdata_i, iob_rdata_o;
  logic [DATA_W/8-1:0] iob_wstrb_i;
  logic                invalidate_i, wtb_empty_o;

  logic [DATA_W-1:0] model [2**ADDR_W];
  logic [DATA_W-1:0] exp_data;
  logic              expect_hit;
  logic              expect_miss;
  logic [15:0]       lfsr_q = 16'd61;
  logic [ADDR_W-1:0] addr_q [$];
  int                errors = 0;
  int                tests = 0;
  int                reads = 0;
  int                writes = 0;

  cache_sim_wrapper #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  initial begin
    for (int a = 0; a < 2**ADDR_W; a++) model[a] = DATA_W'(a); // same rule as the RAM
  end

  // ************************************************************
  // checks
  // ************************************************************

  rdata_check: assert property (@(posedge clk_i) disable iff (reset_i)
    iob_rvalid_o |-> iob_rdata_o == exp_data)
    else begin
      $display("MISMATCH time=%0t signal=iob_rdata_o expected=%h actual=%h",
               $time, $sampled(exp_data), $sampled(iob_rdata_o));
      errors++;
    end

  hit_latency: assert property (@(posedge clk_i) disable iff (reset_i)
    (iob_valid_i && iob_ready_o && iob_wstrb_i == '0 && expect_hit) |=> iob_rvalid_o)
    else begin
      $display("read hit accepted before %0t was not answered one cycle later", $time);
      errors++;
    end

  miss_after_invalidate: assert property (@(posedge clk_i) disable iff (reset_i)
    (iob_valid_i && iob_ready_o && iob_wstrb_i == '0 && expect_miss) |=> !iob_rvalid_o)
    else begin
      $display("read accepted before %0t hit a line that invalidate_i should have cleared",
               $time);
      errors++;
    end

  reset_rvalid: assert property (@(posedge clk_i) $fell(reset_i) |-> !iob_rvalid_o)
    else begin
      $display("MISMATCH time=%0t signal=iob_rvalid_o expected=0 actual=1", $time);
      errors++;
    end

  reset_empty: assert property (@(posedge clk_i) $fell(reset_i) |-> wtb_empty_o)
    else begin
      $display("MISMATCH time=%0t signal=wtb_empty_o expected=1 actual=0", $time);
      errors++;
    end

  full_backpressure: assert property (@(posedge clk_i) disable iff (reset_i)
    uut.u_wtb.full_o |-> !iob_ready_o)
    else begin
      $display("MISMATCH time=%0t signal=iob_ready_o expected=0 actual=1", $time);
      errors++;
    end

  // ************************************************************
  // helpers
  // ************************************************************

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    logic        out;
    v = '0;
    for (int i = 0; i < n; i++) begin
      out    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (out) lfsr_q = lfsr_q ^ 16'hB400; // galois taps 16,14,13,11
      v = {v[30:0], out};
    end
    return v;
  endfunction

  function automatic logic [DATA_W/8-1:0] random_strobe();
    logic [31:0]         bits;
    logic [DATA_W/8-1:0] s;
    bits = draw_bits(DATA_W/8);
    s    = bits[DATA_W/8-1:0];
    if (s == '0) s = '1; // a zero strobe would be a read
    return s;
  endfunction

  // called on a rising edge, returns on the edge that accepts
  task automatic drive_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [DATA_W/8-1:0] strb, input logic hit);
    iob_valid_i <= 1'b1;
    iob_addr_i  <= addr;
    iob_wdata_i <= data;
    iob_wstrb_i <= strb;
    expect_hit  <= hit;
    do @(negedge clk_i); while (!iob_ready_o);
    @(posedge clk_i);
  endtask

  task automatic read_word(input logic [ADDR_W-1:0] addr, input logic hit);
    drive_request(addr, '0, '0, hit);
    exp_data    <= model[addr];
    iob_valid_i <= 1'b0;
    expect_hit  <= 1'b0;
    expect_miss <= 1'b0;
    do @(negedge clk_i); while (!iob_rvalid_o);
    @(posedge clk_i);
    reads++;
  endtask

  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [DATA_W/8-1:0] strb);
    drive_request(addr, data, strb, 1'b0);
    for (int b = 0; b < DATA_W/8; b++) begin
      if (strb[b]) model[addr][b*8 +: 8] = data[b*8 +: 8];
    end
    writes++;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s finished, errors %0d", tests, name,
             errors + uut.u_ctrl.u_props.fails);
  endtask

  // ************************************************************
  // sequence
  // ************************************************************

  initial begin : sequence_run
    logic [ADDR_W-1:0]   a;
    logic [DATA_W-1:0]   d;
    logic [DATA_W/8-1:0] s;
    int                  first;
    reset_i      <= 1'b1;
    iob_valid_i  <= 1'b0;
    iob_addr_i   <= '0;
    iob_wdata_i  <= '0;
    iob_wstrb_i  <= '0;
    invalidate_i <= 1'b0;
    expect_hit   <= 1'b0;
    expect_miss  <= 1'b0;
    exp_data     <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;

    for (int i = 0; i < 4; i++) read_word(ADDR_W'(draw_bits(ADDR_W)), 1'b0);
    end_test("reset content");

    for (int i = 0; i < 4; i++) begin
      a = ADDR_W'(draw_bits(ADDR_W));
      read_word(a, 1'b0);
      read_word(a ^ ADDR_W'(1), 1'b1); // other word of the same line
    end
    end_test("read hit");

    for (int i = 0; i < 4; i++) begin
      a = ADDR_W'(draw_bits(ADDR_W));
      read_word(a, 1'b0);
      addr_q.push_back(a);
    end
    for (int i = 0; i < 4; i++) begin
      d = draw_bits(DATA_W);
      s = random_strobe();
      write_word(addr_q[i], d, s); // line is cached
      a = ADDR_W'(draw_bits(ADDR_W));
      d = draw_bits(DATA_W);
      s = random_strobe();
      write_word(a, d, s);
      addr_q.push_back(a);
    end
    foreach (addr_q[i]) read_word(addr_q[i], 1'b0);
    end_test("byte writes");

    first = addr_q.size();
    for (int i = 0; i < 12; i++) begin
      a = ADDR_W'(draw_bits(ADDR_W));
      d = draw_bits(DATA_W);
      s = random_strobe();
      write_word(a, d, s);
      addr_q.push_back(a);
    end
    iob_valid_i <= 1'b0;
    do @(negedge clk_i); while (!wtb_empty_o);
    @(posedge clk_i);
    for (int i = first; i < addr_q.size(); i++) read_word(addr_q[i], 1'b0);
    end_test("write burst");

    a = addr_q[addr_q.size()-1]; // line of the last read is still cached
    invalidate_i <= 1'b1;
    @(posedge clk_i);
    invalidate_i <= 1'b0;
    expect_miss  <= 1'b1;
    read_word(a, 1'b0);
    foreach (addr_q[i]) read_word(addr_q[i], 1'b0);
    end_test("invalidate");

    repeat (2) @(posedge clk_i); // let the last assertions settle
    $display("tests %0d, reads %0d, writes %0d, errors %0d, bound errors %0d",
             tests, reads, writes, errors, uut.u_ctrl.u_props.fails);
    if (errors == 0 && uut.u_ctrl.u_props.fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, the DUT stopped answering", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- hw/backend_ram.sv
`timescale 1ns/1ps

module backend_ram #(
  parameter int ADDR_W = cache_pkg::DEF_ADDR_W,
  parameter int DATA_W = cache_pkg::DEF_DATA_W
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                be_valid_i,
  input  logic [ADDR_W-1:0]   be_addr_i,
  input  logic [DATA_W-1:0]   be_wdata_i,
  input  logic [DATA_W/8-1:0] be_wstrb_i,
  output logic [DATA_W-1:0]   be_rdata_o,
  output logic                be_rvalid_o,
  output logic                be_ready_o
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];
  logic              rd_en;

  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = DATA_W'(a); // word a holds a
    end
  end

  assign be_ready_o = 1'b1; // never stalls
  assign rd_en      = be_valid_i && !(|be_wstrb_i);

  always_ff @(posedge clk_i) begin
    if (be_valid_i) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (be_wstrb_i[b]) mem[be_addr_i][b*8 +: 8] <= be_wdata_i[b*8 +: 8];
      end
    end
    if (rd_en) be_rdata_o <= mem[be_addr_i];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) be_rvalid_o <= 1'b0;
    else         be_rvalid_o <= rd_en; // one cycle after the read
  end

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
  parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
  parameter int DATA_W        = cache_pkg::DEF_DATA_W,
  parameter int NLINES_W      = cache_pkg::DEF_NLINES_W,
  parameter int WORD_OFFSET_W = cache_pkg::DEF_WORD_OFFSET_W
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // front-end
  input  logic                iob_valid_i,
  input  logic [ADDR_W-1:0]   iob_addr_i,
  input  logic [DATA_W-1:0]   iob_wdata_i,
  input  logic [DATA_W/8-1:0] iob_wstrb_i,
  output logic [DATA_W-1:0]   iob_rdata_o,
  output logic                iob_rvalid_o,
  output logic                iob_ready_o,
  input  logic                invalidate_i,
  // write-through buffer
  output logic                push_o,
  output logic [ADDR_W-1:0]   push_addr_o,
  output logic [DATA_W-1:0]   push_data_o,
  output logic [DATA_W/8-1:0] push_strb_o,
  output logic                pop_o,
  input  logic                full_i,
  input  logic                empty_i,
  input  logic [ADDR_W-1:0]   head_addr_i,
  input  logic [DATA_W-1:0]   head_data_i,
  input  logic [DATA_W/8-1:0] head_strb_i,
  // back-end
  output logic                be_valid_o,
  output logic [ADDR_W-1:0]   be_addr_o,
  output logic [DATA_W-1:0]   be_wdata_o,
  output logic [DATA_W/8-1:0] be_wstrb_o,
  input  logic                be_ready_i,
  input  logic [DATA_W-1:0]   be_rdata_i,
  input  logic                be_rvalid_i
);
  import cache_pkg::*;

  localparam int TAG_W  = ADDR_W - NLINES_W - WORD_OFFSET_W;
  localparam int NLINES = 2 ** NLINES_W;
  localparam int NWORDS = 2 ** (NLINES_W + WORD_OFFSET_W);

  cache_state_t state_q, state_d;

  logic [TAG_W-1:0]  tag_mem  [NLINES];
  logic [DATA_W-1:0] data_mem [NWORDS];
  logic [NLINES-1:0] valid_q;

  logic [TAG_W-1:0]         in_tag;
  logic [NLINES_W-1:0]      in_idx;
  logic [WORD_OFFSET_W-1:0] in_off;
  logic [TAG_W-1:0]         tag_q;
  logic [NLINES_W-1:0]      idx_q;
  logic [WORD_OFFSET_W-1:0] off_q;
  logic [WORD_OFFSET_W-1:0] issue_cnt_q;
  logic [WORD_OFFSET_W-1:0] fill_cnt_q;

  logic accept, accept_rd, accept_wr;
  logic in_hit, wr_hit, rd_hit;
  logic refilling, fill_en, fill_last;

  // ************************************************************
  // front-end lookup
  // ************************************************************

  assign {in_tag, in_idx, in_off} = iob_addr_i;

  assign iob_ready_o = (state_q == IDLE) && !full_i; // buffer back-pressure
  assign accept      = iob_valid_i && iob_ready_o;
  assign accept_wr   = accept && (|iob_wstrb_i);
  assign accept_rd   = accept && !(|iob_wstrb_i);

  assign in_hit = valid_q[in_idx] && (tag_mem[in_idx] == in_tag);
  assign wr_hit = accept_wr && in_hit;                // no write allocate
  assign rd_hit = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);

  assign iob_rdata_o  = data_mem[{idx_q, off_q}];
  assign iob_rvalid_o = ((state_q == LOOKUP) && rd_hit) || (state_q == RESPOND);

  // every write goes through the buffer
  assign push_o      = accept_wr;
  assign push_addr_o = iob_addr_i;
  assign push_data_o = iob_wdata_i;
  assign push_strb_o = iob_wstrb_i;

  always_ff @(posedge clk_i) begin
    if (accept_rd) begin
      {tag_q, idx_q, off_q} <= iob_addr_i; // held for lookup and refill
    end
  end

  // ************************************************************
  // state machine
  // ************************************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:        if (accept_rd) state_d = LOOKUP;
      LOOKUP: begin
        if (rd_hit) state_d = IDLE;
        else        state_d = empty_i ? REFILL_REQ : WAIT_WTB;
      end
      WAIT_WTB:    if (empty_i) state_d = REFILL_REQ; // earlier writes reach RAM first
      REFILL_REQ:  if (be_ready_i && (issue_cnt_q == '1)) state_d = REFILL_WAIT;
      REFILL_WAIT: if (fill_last) state_d = RESPOND;
      RESPOND:     state_d = IDLE;
      default:     state_d = IDLE;
    endcase
  end

  assign refilling = (state_q == REFILL_REQ) || (state_q == REFILL_WAIT);
  assign fill_en   = refilling && be_rvalid_i;
  assign fill_last = fill_en && (fill_cnt_q == '1);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      fill_cnt_q  <= '0;
    end else begin
      state_q <= state_d;
      if ((state_q == REFILL_REQ) && be_ready_i) begin
        issue_cnt_q <= issue_cnt_q + 1'b1; // wraps to zero after the last word
      end
      if (fill_en) begin
        fill_cnt_q <= fill_cnt_q + 1'b1;
      end
    end
  end

  // ************************************************************
  // arrays
  // ************************************************************

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;
    end else if (fill_last) begin
      valid_q[idx_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_last) begin
      tag_mem[idx_q] <= tag_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_en) begin
      data_mem[{idx_q, fill_cnt_q}] <= be_rdata_i;
    end else if (wr_hit) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (iob_wstrb_i[b]) data_mem[{in_idx, in_off}][b*8 +: 8] <= iob_wdata_i[b*8 +: 8];
      end
    end
  end

  // ************************************************************
  // back-end port, refill reads win over buffer drain
  // ************************************************************

  always_comb begin
    if (state_q == REFILL_REQ) begin
      be_valid_o = 1'b1;
      be_addr_o  = {tag_q, idx_q, issue_cnt_q}; // line words in order
      be_wdata_o = '0;
      be_wstrb_o = '0;
    end else begin
      be_valid_o = !refilling && !empty_i;
      be_addr_o  = head_addr_i;
      be_wdata_o = head_data_i;
      be_wstrb_o = head_strb_i;
    end
  end

  assign pop_o = !refilling && !empty_i && be_ready_i; // drained at acceptance

endmodule

//--- hw/cache_pkg.sv
package cache_pkg;

  // ************************************************************
  // controller states
  // ************************************************************

  typedef enum logic [2:0] {
    IDLE,        // waiting for a front-end request
    LOOKUP,      // tag compare on the latched read address
    WAIT_WTB,    // miss, buffer still draining
    REFILL_REQ,  // issuing line reads
    REFILL_WAIT, // collecting the last read words
    RESPOND      // answer from the refilled line
  } cache_state_t;

  // ************************************************************
  // default geometry
  // ************************************************************

  localparam int DEF_ADDR_W        = 10; // word address
  localparam int DEF_DATA_W        = 32;
  localparam int DEF_NLINES_W      = 4;  // log2 lines
  localparam int DEF_WORD_OFFSET_W = 2;  // log2 words per line
  localparam int DEF_WTBUF_DEPTH_W = 2;  // log2 buffer entries

  // front-end and back-end share these widths, so a refill moves
  // one line word per back-end read

endpackage

//--- hw/cache_sim_wrapper.sv
`timescale 1ns/1ps

module cache_sim_wrapper #(
  parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
  parameter int DATA_W        = cache_pkg::DEF_DATA_W,
  parameter int NLINES_W      = cache_pkg::DEF_NLINES_W,
  parameter int WORD_OFFSET_W = cache_pkg::DEF_WORD_OFFSET_W,
  parameter int WTBUF_DEPTH_W = cache_pkg::DEF_WTBUF_DEPTH_W
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                iob_valid_i,
  input  logic [ADDR_W-1:0]   iob_addr_i,
  input  logic [DATA_W-1:0]   iob_wdata_i,
  input  logic [DATA_W/8-1:0] iob_wstrb_i,
  output logic [DATA_W-1:0]   iob_rdata_o,
  output logic                iob_rvalid_o,
  output logic                iob_ready_o,
  input  logic                invalidate_i,
  output logic                wtb_empty_o
);

  // back-end
  logic                be_valid, be_ready, be_rvalid;
  logic [ADDR_W-1:0]   be_addr;
  logic [DATA_W-1:0]   be_wdata, be_rdata;
  logic [DATA_W/8-1:0] be_wstrb;

  // buffer
  logic                push, pop, full;
  logic [ADDR_W-1:0]   push_addr, head_addr;
  logic [DATA_W-1:0]   push_data, head_data;
  logic [DATA_W/8-1:0] push_strb, head_strb;

  cache_ctrl #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .NLINES_W(NLINES_W), .WORD_OFFSET_W(WORD_OFFSET_W)
  ) u_ctrl (
    .clk_i(clk_i), .reset_i(reset_i),
    .iob_valid_i(iob_valid_i), .iob_addr_i(iob_addr_i), .iob_wdata_i(iob_wdata_i),
    .iob_wstrb_i(iob_wstrb_i), .iob_rdata_o(iob_rdata_o), .iob_rvalid_o(iob_rvalid_o),
    .iob_ready_o(iob_ready_o), .invalidate_i(invalidate_i),
    .push_o(push), .push_addr_o(push_addr), .push_data_o(push_data),
    .push_strb_o(push_strb), .pop_o(pop), .full_i(full), .empty_i(wtb_empty_o),
    .head_addr_i(head_addr), .head_data_i(head_data), .head_strb_i(head_strb),
    .be_valid_o(be_valid), .be_addr_o(be_addr), .be_wdata_o(be_wdata),
    .be_wstrb_o(be_wstrb), .be_ready_i(be_ready), .be_rdata_i(be_rdata),
    .be_rvalid_i(be_rvalid)
  );

  wt_buffer #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .WTBUF_DEPTH_W(WTBUF_DEPTH_W)
  ) u_wtb (
    .clk_i(clk_i), .reset_i(reset_i),
    .push_i(push), .push_addr_i(push_addr), .push_data_i(push_data),
    .push_strb_i(push_strb), .pop_i(pop), .full_o(full), .empty_o(wtb_empty_o),
    .head_addr_o(head_addr), .head_data_o(head_data), .head_strb_o(head_strb)
  );

  backend_ram #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W)
  ) u_ram (
    .clk_i(clk_i), .reset_i(reset_i),
    .be_valid_i(be_valid), .be_addr_i(be_addr), .be_wdata_i(be_wdata),
    .be_wstrb_i(be_wstrb), .be_rdata_o(be_rdata), .be_rvalid_o(be_rvalid),
    .be_ready_o(be_ready)
  );

endmodule

//--- hw/wt_buffer.sv
`timescale 1ns/1ps

module wt_buffer #(
  parameter int ADDR_W        = cache_pkg::DEF_ADDR_W,
  parameter int DATA_W        = cache_pkg::DEF_DATA_W,
  parameter int WTBUF_DEPTH_W = cache_pkg::DEF_WTBUF_DEPTH_W
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                push_i,
  input  logic [ADDR_W-1:0]   push_addr_i,
  input  logic [DATA_W-1:0]   push_data_i,
  input  logic [DATA_W/8-1:0] push_strb_i,
  input  logic                pop_i,
  output logic                full_o,
  output logic                empty_o,
  output logic [ADDR_W-1:0]   head_addr_o,
  output logic [DATA_W-1:0]   head_data_o,
  output logic [DATA_W/8-1:0] head_strb_o
);

  localparam int DEPTH = 2 ** WTBUF_DEPTH_W;

  logic [ADDR_W-1:0]   addr_mem [DEPTH];
  logic [DATA_W-1:0]   data_mem [DEPTH];
  logic [DATA_W/8-1:0] strb_mem [DEPTH];

  logic [WTBUF_DEPTH_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [WTBUF_DEPTH_W:0]   count_q;
  logic                     do_push, do_pop;

  assign full_o  = (count_q == DEPTH[WTBUF_DEPTH_W:0]);
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign head_addr_o = addr_mem[rd_ptr_q]; // oldest entry
  assign head_data_o = data_mem[rd_ptr_q];
  assign head_strb_o = strb_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      data_mem[wr_ptr_q] <= push_data_i;
      strb_mem[wr_ptr_q] <= push_strb_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1; // pointers wrap
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop)      count_q <= count_q + 1'b1;
      else if (do_pop && !do_push) count_q <= count_q - 1'b1;
    end
  end

endmodule

//--- list.f
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/wt_buffer.sv
hw/backend_ram.sv
hw/cache_sim_wrapper.sv
bench/cache_props.sv
bench/cache_tb.sv
